/* source/fragment_dispatcher.sv */
`timescale 1ns/1ps

module fragment_dispatcher (
    input  logic                                           clock,
    input  logic                                           reset_n,
    input  udp_reassembly_pkg::fragment_beat_t             in_beat,
    input  logic                                           in_valid,
    input  logic [udp_reassembly_pkg::num_slots-1:0]       slot_ready,
    output udp_reassembly_pkg::byte_t                      slot_data,
    output logic [udp_reassembly_pkg::num_slots-1:0]       slot_data_enable,
    output logic [udp_reassembly_pkg::num_slots-1:0]       slot_data_last,
    output udp_reassembly_pkg::packet_id_t                 slot_fragment_id,
    output udp_reassembly_pkg::drop_count_t                drop_count
);

    typedef enum logic [1:0] {
        state_idle,
        state_forward,
        state_discard
    } state_t;

    state_t                          state;
    state_t                          next_state;
    udp_reassembly_pkg::slot_index_t selected_slot;
    udp_reassembly_pkg::slot_index_t next_selected_slot;
    udp_reassembly_pkg::slot_index_t free_slot;
    logic                            free_found;
    udp_reassembly_pkg::drop_count_t next_drop_count;

    // Byte and ID go to every slot, the enables pick the target
    assign slot_data        = in_beat.data;
    assign slot_fragment_id = in_beat.packet_id;

    // Lowest index wins
    always_comb begin
        free_found = 1'b0;
        free_slot  = '0;
        for (int i = udp_reassembly_pkg::num_slots - 1; i >= 0; i--) begin
            if (slot_ready[i]) begin
                free_found = 1'b1;
                free_slot  = udp_reassembly_pkg::slot_index_t'(i);
            end
        end
    end

    always_comb begin
        next_state         = state;
        next_selected_slot = selected_slot;
        next_drop_count    = drop_count;
        slot_data_enable   = '0;
        slot_data_last     = '0;

        case (state)
            state_idle: begin
                if (in_valid && free_found) begin
                    slot_data_enable[free_slot] = 1'b1;
                    slot_data_last[free_slot]   = in_beat.last;
                    next_selected_slot          = free_slot;
                    if (!in_beat.last) begin
                        next_state = state_forward;
                    end
                end else if (in_valid) begin
                    // No room, count once and swallow the rest
                    if (drop_count != '1) begin
                        next_drop_count = drop_count + 1'b1;
                    end
                    if (!in_beat.last) begin
                        next_state = state_discard;
                    end
                end
            end
            state_forward: begin
                if (in_valid) begin
                    slot_data_enable[selected_slot] = 1'b1;
                    slot_data_last[selected_slot]   = in_beat.last;
                    if (in_beat.last) begin
                        next_state = state_idle;
                    end
                end
            end
            state_discard: begin
                if (in_valid && in_beat.last) begin
                    next_state = state_idle;
                end
            end
            default: begin
                next_state = state_idle;
            end
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state         <= state_idle;
            selected_slot <= '0;
            drop_count    <= '0;
        end else begin
            state         <= next_state;
            selected_slot <= next_selected_slot;
            drop_count    <= next_drop_count;
        end
    end

endmodule

/* source/slot_drain_arbiter.sv */
`timescale 1ns/1ps

module slot_drain_arbiter (
    input  logic                                     clock,
    input  logic                                     reset_n,
    input  logic [udp_reassembly_pkg::num_slots-1:0] slot_data_ready,
    input  logic [udp_reassembly_pkg::num_slots-1:0] slot_push_data_valid,
    input  udp_reassembly_pkg::slot_word_t           slot_push_data
                                                     [udp_reassembly_pkg::num_slots],
    input  udp_reassembly_pkg::packet_id_t           slot_packet_id
                                                     [udp_reassembly_pkg::num_slots],
    output logic [udp_reassembly_pkg::num_slots-1:0] slot_push_data_enable,
    output udp_reassembly_pkg::packet_beat_t         out_beat,
    output logic                                     out_valid
);

    typedef enum logic {
        state_idle,
        state_draining
    } state_t;

    state_t                          state;
    state_t                          next_state;
    udp_reassembly_pkg::slot_index_t grant;
    udp_reassembly_pkg::slot_index_t next_grant;
    udp_reassembly_pkg::slot_index_t candidate;
    logic                            candidate_found;
    logic                            read_now;
    udp_reassembly_pkg::slot_word_t  hold_word;
    logic                            hold_valid;
    udp_reassembly_pkg::packet_id_t  packet_id;

    //////////////////////////////////////////////////////////////////////
    // Grant selection
    //////////////////////////////////////////////////////////////////////

    // data_ready trails the slot state by a cycle, so also need data present
    always_comb begin
        candidate_found = 1'b0;
        candidate       = '0;
        for (int i = udp_reassembly_pkg::num_slots - 1; i >= 0; i--) begin
            if (slot_data_ready[i] && slot_push_data_valid[i]) begin
                candidate_found = 1'b1;
                candidate       = udp_reassembly_pkg::slot_index_t'(i);
            end
        end
    end

    always_comb begin
        next_state            = state;
        next_grant            = grant;
        slot_push_data_enable = '0;
        read_now              = (state == state_draining) && slot_push_data_valid[grant];

        if (state == state_idle) begin
            if (candidate_found) begin
                next_grant = candidate;
                next_state = state_draining;
            end
        end else begin
            slot_push_data_enable[grant] = read_now;
            // Slot ran dry, the held word goes out as last this cycle
            if (!read_now) begin
                next_state = state_idle;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Output stage
    //////////////////////////////////////////////////////////////////////

    assign out_valid          = hold_valid;
    assign out_beat.data      = hold_word[7:0];
    assign out_beat.first     = hold_word[8];
    assign out_beat.last      = !slot_push_data_valid[grant];
    assign out_beat.packet_id = packet_id;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state      <= state_idle;
            grant      <= '0;
            hold_valid <= 1'b0;
        end else begin
            state      <= next_state;
            grant      <= next_grant;
            hold_valid <= read_now;
        end
    end

    always_ff @(posedge clock) begin
        if (read_now) begin
            hold_word <= slot_push_data[grant];
        end
        if (state == state_idle && candidate_found) begin
            packet_id <= slot_packet_id[candidate];
        end
    end

endmodule

/* source/synchronous_fifo.sv */
`timescale 1ns/1ps

module synchronous_fifo #(
    parameter int data_width = 8,
    parameter int data_depth = 16
) (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic                  write_enable,
    input  logic [data_width-1:0] write_data,
    input  logic                  read_enable,
    output logic [data_width-1:0] read_data,
    output logic                  read_data_valid,
    output logic                  full,
    output logic                  empty
);

    localparam int address_width = $clog2(data_depth);
    localparam int count_width   = $clog2(data_depth + 1);

    logic [data_width-1:0]    memory [data_depth];
    logic [address_width-1:0] write_pointer;
    logic [address_width-1:0] read_pointer;
    logic [count_width-1:0]   count;
    logic                     do_write;
    logic                     do_read;

    assign full     = (count == count_width'(data_depth));
    assign empty    = (count == '0);
    assign do_write = write_enable && !full;
    assign do_read  = read_enable && !empty;

    // Head word is shown without waiting for a read
    assign read_data       = memory[read_pointer];
    assign read_data_valid = !empty;

    always_ff @(posedge clock) begin
        if (do_write) begin
            memory[write_pointer] <= write_data;
        end
    end

    // Pointers wrap at the depth, which need not be a power of two
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            write_pointer <= '0;
            read_pointer  <= '0;
            count         <= '0;
        end else begin
            if (do_write) begin
                write_pointer <= (write_pointer == address_width'(data_depth - 1)) ?
                                 '0 : write_pointer + 1'b1;
            end
            if (do_read) begin
                read_pointer <= (read_pointer == address_width'(data_depth - 1)) ?
                                '0 : read_pointer + 1'b1;
            end
            if (do_write && !do_read) begin
                count <= count + 1'b1;
            end else if (do_read && !do_write) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* source/udp_fragment_slot.sv */
`timescale 1ns/1ps

module udp_fragment_slot (
    input  logic                           clock,
    input  logic                           reset_n,
    input  udp_reassembly_pkg::byte_t      data,
    input  logic                           data_enable,
    input  logic                           data_last,
    input  logic                           push_data_enable,
    input  udp_reassembly_pkg::packet_id_t fragment_id,
    output logic                           ready,
    output logic                           data_ready,
    output udp_reassembly_pkg::slot_word_t push_data,
    output logic                           push_data_valid,
    output udp_reassembly_pkg::packet_id_t current_packet_id
);

    typedef enum logic [1:0] {
        state_idle,
        state_capture,
        state_drain
    } state_t;

    state_t                         state;
    state_t                         next_state;
    logic                           next_ready;
    logic                           next_data_ready;
    udp_reassembly_pkg::packet_id_t next_packet_id;
    udp_reassembly_pkg::slot_word_t buffer_data;
    udp_reassembly_pkg::slot_word_t next_buffer_data;
    logic                           buffer_data_valid;
    logic                           next_buffer_data_valid;
    logic                           fifo_empty;

    // Fragment storage, one word per byte
    synchronous_fifo #(
        .data_width ($bits(udp_reassembly_pkg::slot_word_t)),
        .data_depth (udp_reassembly_pkg::slot_fifo_depth)
    ) i_fragment_fifo (
        .clock           (clock),
        .reset_n         (reset_n),
        .write_enable    (buffer_data_valid),
        .write_data      (buffer_data),
        .read_enable     (push_data_enable),
        .read_data       (push_data),
        .read_data_valid (push_data_valid),
        .full            (),
        .empty           (fifo_empty)
    );

    always_comb begin
        next_state             = state;
        next_packet_id         = current_packet_id;
        next_buffer_data       = buffer_data;
        next_buffer_data_valid = 1'b0;
        next_ready             = 1'b0;
        next_data_ready        = 1'b0;

        case (state)
            state_idle: begin
                next_ready     = 1'b1;
                // Follow the incoming ID so the first beat's value sticks
                next_packet_id = fragment_id;
                if (data_enable) begin
                    next_buffer_data       = {1'b1, data};
                    next_buffer_data_valid = 1'b1;
                    next_state             = data_last ? state_drain : state_capture;
                end
            end
            state_capture: begin
                if (data_enable) begin
                    next_buffer_data       = {1'b0, data};
                    next_buffer_data_valid = 1'b1;
                    if (data_last) begin
                        next_state = state_drain;
                    end
                end
            end
            state_drain: begin
                next_data_ready = 1'b1;
                // The last byte may still sit in the buffer register
                if (fifo_empty && !buffer_data_valid) begin
                    next_state = state_idle;
                end
            end
            default: begin
                next_state = state_idle;
            end
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state             <= state_idle;
            ready             <= 1'b0;
            data_ready        <= 1'b0;
            buffer_data_valid <= 1'b0;
        end else begin
            state             <= next_state;
            ready             <= next_ready;
            data_ready        <= next_data_ready;
            buffer_data_valid <= next_buffer_data_valid;
        end
    end

    always_ff @(posedge clock) begin
        buffer_data       <= next_buffer_data;
        current_packet_id <= next_packet_id;
    end

endmodule

/* source/udp_reassembly.sv */
`timescale 1ns/1ps

module udp_reassembly (
    input  logic                                clock,
    input  logic                                reset_n,
    input  udp_reassembly_pkg::fragment_beat_t  in_beat,
    input  logic                                in_valid,
    output udp_reassembly_pkg::packet_beat_t    out_beat,
    output logic                                out_valid,
    output udp_reassembly_pkg::drop_count_t     drop_count
);

    udp_reassembly_pkg::byte_t                slot_data;
    udp_reassembly_pkg::packet_id_t           slot_fragment_id;
    logic [udp_reassembly_pkg::num_slots-1:0] slot_ready;
    logic [udp_reassembly_pkg::num_slots-1:0] slot_data_enable;
    logic [udp_reassembly_pkg::num_slots-1:0] slot_data_last;
    logic [udp_reassembly_pkg::num_slots-1:0] slot_data_ready;
    logic [udp_reassembly_pkg::num_slots-1:0] slot_push_data_valid;
    logic [udp_reassembly_pkg::num_slots-1:0] slot_push_data_enable;
    udp_reassembly_pkg::slot_word_t           slot_push_data [udp_reassembly_pkg::num_slots];
    udp_reassembly_pkg::packet_id_t           slot_packet_id [udp_reassembly_pkg::num_slots];

    fragment_dispatcher i_dispatcher (
        .clock            (clock),
        .reset_n          (reset_n),
        .in_beat          (in_beat),
        .in_valid         (in_valid),
        .slot_ready       (slot_ready),
        .slot_data        (slot_data),
        .slot_data_enable (slot_data_enable),
        .slot_data_last   (slot_data_last),
        .slot_fragment_id (slot_fragment_id),
        .drop_count       (drop_count)
    );

    // Slot array
    for (genvar i = 0; i < udp_reassembly_pkg::num_slots; i++) begin : g_slot
        udp_fragment_slot i_slot (
            .clock             (clock),
            .reset_n           (reset_n),
            .data              (slot_data),
            .data_enable       (slot_data_enable[i]),
            .data_last         (slot_data_last[i]),
            .push_data_enable  (slot_push_data_enable[i]),
            .fragment_id       (slot_fragment_id),
            .ready             (slot_ready[i]),
            .data_ready        (slot_data_ready[i]),
            .push_data         (slot_push_data[i]),
            .push_data_valid   (slot_push_data_valid[i]),
            .current_packet_id (slot_packet_id[i])
        );
    end

    slot_drain_arbiter i_arbiter (
        .clock                 (clock),
        .reset_n               (reset_n),
        .slot_data_ready       (slot_data_ready),
        .slot_push_data_valid  (slot_push_data_valid),
        .slot_push_data        (slot_push_data),
        .slot_packet_id        (slot_packet_id),
        .slot_push_data_enable (slot_push_data_enable),
        .out_beat              (out_beat),
        .out_valid             (out_valid)
    );

endmodule

/* source/udp_reassembly_pkg.sv */
package udp_reassembly_pkg;

    //////////////////////////////////////////////////////////////////////
    // Sizing
    //////////////////////////////////////////////////////////////////////

    // Reassembly slots behind the dispatcher
    localparam int num_slots = 2;

    // Bytes per slot FIFO
    localparam int slot_fifo_depth = 4096;

    //////////////////////////////////////////////////////////////////////
    // Basic types
    //////////////////////////////////////////////////////////////////////

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] packet_id_t;
    typedef logic [15:0] drop_count_t;

    // Bit 8 marks the first byte of a fragment, bits 7:0 carry the byte
    typedef logic [8:0] slot_word_t;

    typedef logic [$clog2(num_slots)-1:0] slot_index_t;

    //////////////////////////////////////////////////////////////////////
    // Stream beats
    //////////////////////////////////////////////////////////////////////

    // Input side, packet_id only valid on the first beat
    typedef struct packed {
        byte_t      data;
        logic       last;
        packet_id_t packet_id;
    } fragment_beat_t;

    typedef struct packed {
        byte_t      data;
        logic       first;
        logic       last;
        packet_id_t packet_id;
    } packet_beat_t;

endpackage

/* test/udp_reassembly_tb.sv */
`timescale 1ns/1ps

module udp_reassembly_tb;

    localparam int timeout_cycles = 20000;

    typedef udp_reassembly_pkg::byte_t byte_queue_t[$];

    typedef struct packed {
        udp_reassembly_pkg::packet_id_t packet_id;
        logic [15:0]                    length;
    } rx_record_t;

    logic                               clock;
    logic                               reset_n;
    udp_reassembly_pkg::fragment_beat_t in_beat;
    logic                               in_valid;
    udp_reassembly_pkg::packet_beat_t   out_beat;
    logic                               out_valid;
    udp_reassembly_pkg::drop_count_t    drop_count;

    integer seed;
    int     cycle_count;

    // Scoreboard, bytes keyed by {packet id, byte index}
    udp_reassembly_pkg::byte_t      expected_data [logic [31:0]];
    int                             expected_length [udp_reassembly_pkg::packet_id_t];
    udp_reassembly_pkg::packet_id_t expected_order[$];
    rx_record_t                     received[$];

    // Monitor state
    logic                           in_packet;
    udp_reassembly_pkg::packet_id_t current_id;
    int                             beat_index;

    udp_reassembly i_dut (
        .clock      (clock),
        .reset_n    (reset_n),
        .in_beat    (in_beat),
        .in_valid   (in_valid),
        .out_beat   (out_beat),
        .out_valid  (out_valid),
        .drop_count (drop_count)
    );

    always #10 clock = ~clock;

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: the tests were still running after %0d clock cycles", cycle_count);
            $display("Checks failed");
            $fatal(1, "run aborted");
        end
    end

    task automatic report_error(input string message);
        $display("error at %0t ns: %s", $time, message);
        $display("Checks failed");
        $fatal(1, "run stopped at first error");
    endtask

    function automatic byte_queue_t random_bytes(input int count);
        byte_queue_t bytes;
        for (int i = 0; i < count; i++) begin
            bytes.push_back(udp_reassembly_pkg::byte_t'($random(seed)));
        end
        return bytes;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Output monitor
    //////////////////////////////////////////////////////////////////////

    task automatic check_output_beat();
        udp_reassembly_pkg::packet_id_t id;
        id = out_beat.packet_id;
        if (!in_packet) begin
            assert (out_beat.first) else report_error("packet starts without first flag");
            assert (expected_length.exists(id))
                else report_error($sformatf("unexpected packet id %h on output", id));
            assert (expected_order.size() > 0 && expected_order[0] == id)
                else report_error($sformatf("packet %h delivered out of order", id));
            in_packet  = 1'b1;
            current_id = id;
            beat_index = 0;
        end else begin
            assert (!out_beat.first)
                else report_error($sformatf("first flag inside packet %h", current_id));
            assert (id == current_id)
                else report_error($sformatf("id %h inside packet %h", id, current_id));
        end
        assert (out_beat.data == expected_data[{current_id, 16'(beat_index)}])
            else report_error($sformatf("packet %h byte %0d is %h, expected %h", current_id,
                beat_index, out_beat.data, expected_data[{current_id, 16'(beat_index)}]));
        assert (out_beat.last == (beat_index == expected_length[current_id] - 1))
            else report_error($sformatf("packet %h last flag wrong on byte %0d",
                current_id, beat_index));
        beat_index++;
        if (out_beat.last) begin
            received.push_back('{packet_id: current_id, length: 16'(beat_index)});
            // Retire so a reused id is expected afresh
            for (int i = 0; i < beat_index; i++) begin
                expected_data.delete({current_id, 16'(i)});
            end
            expected_length.delete(current_id);
            void'(expected_order.pop_front());
            in_packet = 1'b0;
        end
    endtask

    always @(negedge clock) begin
        if (reset_n && out_valid) begin
            check_output_beat();
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic send_fragment(input udp_reassembly_pkg::packet_id_t id,
                                 input byte_queue_t bytes, input bit delivered);
        if (delivered) begin
            expected_length[id] = bytes.size();
            foreach (bytes[i]) begin
                expected_data[{id, 16'(i)}] = bytes[i];
            end
            expected_order.push_back(id);
        end
        foreach (bytes[i]) begin
            @(posedge clock);
            #2;
            in_valid          = 1'b1;
            in_beat.data      = bytes[i];
            in_beat.last      = (i == bytes.size() - 1);
            in_beat.packet_id = (i == 0) ? id : '0;
        end
        @(posedge clock);
        #2;
        in_valid = 1'b0;
        in_beat  = '0;
        // Three idle cycles in total before the next fragment
        repeat (2) @(posedge clock);
    endtask

    task automatic wait_delivered();
        while (expected_order.size() != 0) begin
            @(posedge clock);
        end
        repeat (4) @(posedge clock);
    endtask

    task automatic apply_reset();
        reset_n = 1'b0;
        repeat (3) @(posedge clock);
        #2;
        reset_n = 1'b1;
        repeat (2) @(posedge clock);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_single_fragments();
        send_fragment(16'h1234, random_bytes(8), 1'b1);
        wait_delivered();
        assert (received[$].packet_id == 16'h1234 && received[$].length == 8)
            else report_error("8-byte fragment not delivered as one packet");
        send_fragment(16'h00ab, random_bytes(1), 1'b1);
        wait_delivered();
        assert (received[$].packet_id == 16'h00ab && received[$].length == 1)
            else report_error("1-byte fragment not delivered as one packet");
    endtask

    task automatic test_two_slots();
        udp_reassembly_pkg::drop_count_t drops_before;
        drops_before = drop_count;
        // Short second fragment is ready while the first still drains
        send_fragment(16'h2001, random_bytes(40), 1'b1);
        send_fragment(16'h2002, random_bytes(12), 1'b1);
        wait_delivered();
        assert (drop_count == drops_before) else report_error("drop count changed");
    endtask

    task automatic test_drop_when_full();
        udp_reassembly_pkg::drop_count_t drops_before;
        drops_before = drop_count;
        // Shorter second fragment, so the third lands while slot 0 still drains
        send_fragment(16'h3001, random_bytes(1000), 1'b1);
        send_fragment(16'h3002, random_bytes(600), 1'b1);
        send_fragment(16'h3003, random_bytes(1000), 1'b0);
        assert (drop_count == udp_reassembly_pkg::drop_count_t'(drops_before + 1))
            else report_error($sformatf("drop count %0d, expected %0d", drop_count,
                drops_before + 1));
        wait_delivered();
        assert (drop_count == udp_reassembly_pkg::drop_count_t'(drops_before + 1))
            else report_error("drop count moved after the drop");
    endtask

    task automatic test_random_fragments();
        udp_reassembly_pkg::drop_count_t drops_before;
        udp_reassembly_pkg::packet_id_t  id;
        int                              length;
        drops_before = drop_count;
        for (int n = 0; n < 20; n++) begin
            id     = udp_reassembly_pkg::packet_id_t'($random(seed));
            length = 1 + ($unsigned($random(seed)) % 64);
            send_fragment(id, random_bytes(length), 1'b1);
            wait_delivered();
        end
        assert (drop_count == drops_before) else report_error("drops during random test");
    endtask

    task automatic test_reset_mid_fragment();
        byte_queue_t bytes;
        // First packet is still draining when reset hits the second fragment
        send_fragment(16'h5001, random_bytes(30), 1'b1);
        bytes = random_bytes(5);
        foreach (bytes[i]) begin
            @(posedge clock);
            #2;
            in_valid          = 1'b1;
            in_beat.data      = bytes[i];
            in_beat.last      = 1'b0;
            in_beat.packet_id = (i == 0) ? 16'h5000 : '0;
        end
        @(posedge clock);
        #2;
        reset_n  = 1'b0;
        in_valid = 1'b0;
        in_beat  = '0;
        repeat (3) begin
            @(negedge clock);
            assert (!out_valid) else report_error("out_valid high during reset");
            assert (drop_count == '0) else report_error("drop count not cleared by reset");
        end
        // Packet cut short by reset is abandoned
        expected_data.delete();
        expected_length.delete();
        expected_order.delete();
        in_packet = 1'b0;
        @(posedge clock);
        #2;
        reset_n = 1'b1;
        repeat (2) @(posedge clock);
        send_fragment(16'h5005, random_bytes(12), 1'b1);
        wait_delivered();
    endtask

    initial begin
        clock       = 1'b0;
        reset_n     = 1'b0;
        in_valid    = 1'b0;
        in_beat     = '0;
        seed        = 32'h9765;
        cycle_count = 0;
        in_packet   = 1'b0;
        current_id  = '0;
        beat_index  = 0;
        apply_reset();
        test_single_fragments();
        test_two_slots();
        test_drop_when_full();
        test_random_fragments();
        test_reset_mid_fragment();
        $display("All checks passed");
        $finish;
    end

endmodule

/* udp_reassembly.f */
source/udp_reassembly_pkg.sv
source/synchronous_fifo.sv
source/udp_fragment_slot.sv
source/fragment_dispatcher.sv
source/slot_drain_arbiter.sv
source/udp_reassembly.sv
test/udp_reassembly_tb.sv
